//--- rtl/icache_params.svh
// cache geometry, address split and queue depth macros
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// ***************************************************************************
// address split
// ***************************************************************************

// fetch address width
`define ICACHE_ADDR_W 32
// byte offset inside one 64-bit line
`define ICACHE_OFS_W 3
// line index into the direct-mapped array
`define ICACHE_IDX_W 7
// whatever is left above index and offset
`define ICACHE_TAG_W (`ICACHE_ADDR_W - `ICACHE_IDX_W - `ICACHE_OFS_W)

// ***************************************************************************
// storage
// ***************************************************************************

// 128 lines of 64 bits, 1 KB in total
`define ICACHE_D 128
`define ICACHE_LINE_W 64

// victim FIFO depth
`define ICACHE_VT_N 4

// memory requests in flight, one demand plus one prefetch
`define ICACHE_PEND_N 2

`endif

//--- rtl/icache_pkg.sv
// package icache_pkg: fetch address union, line type, fetch, memory and fill structs
`include "icache_params.svh"

package icache_pkg;

	// ***********************************************************************
	// fetch address
	// ***********************************************************************

	// field view, as the cache reads it
	typedef struct packed {
		logic [`ICACHE_TAG_W-1:0] tag;
		logic [`ICACHE_IDX_W-1:0] idx;
		logic [`ICACHE_OFS_W-1:0] ofs;
	} fetch_addr_t;

	// raw view for address arithmetic, field view for lookups
	typedef union packed {
		logic [`ICACHE_ADDR_W-1:0] raw;
		fetch_addr_t f;
	} fetch_addr_u;

	// one cache line
	typedef logic [`ICACHE_LINE_W-1:0] line_t;

	// ***********************************************************************
	// port bundles
	// ***********************************************************************

	// fetch response, data only valid with hit
	typedef struct packed {
		logic hit;
		line_t data;
	} fetch_rsp_t;

	// line address sent to memory
	typedef struct packed {
		logic [`ICACHE_TAG_W-1:0] tag;
		logic [`ICACHE_IDX_W-1:0] idx;
	} mem_req_t;

	typedef struct packed {
		line_t data;
	} mem_rsp_t;

	// miss controller to line array
	typedef struct packed {
		logic [`ICACHE_TAG_W-1:0] tag;
		logic [`ICACHE_IDX_W-1:0] idx;
		line_t data;
	} cache_fill_t;

endpackage

//--- rtl/icache_mem.sv
// icache_mem: direct-mapped line array, victim FIFO, demand and prefetch lookup, fill and promotion
`timescale 1ns/100ps
`include "icache_params.svh"

module icache_mem (
	input  logic                    clk,
	input  logic                    rst,

	// demand lookup
	input  icache_pkg::fetch_addr_u rd_addr_i,
	output icache_pkg::fetch_rsp_t  rd_rsp_o,

	// prefetch probe
	input  icache_pkg::fetch_addr_u pf_addr_i,
	input  logic                    pf_prefetching_i,
	output logic                    pf_hit_o,

	// line fill from the miss controller
	input  logic                    fill_vld_i,
	input  icache_pkg::cache_fill_t fill_i
);

	import icache_pkg::*;

	localparam int VT_PTR_W = $clog2(`ICACHE_VT_N);

	// main array
	line_t                    data_r [`ICACHE_D];
	logic [`ICACHE_TAG_W-1:0] tag_r  [`ICACHE_D];
	logic [`ICACHE_D-1:0]     vld_r;

	// victim FIFO
	line_t                    vt_data_r [`ICACHE_VT_N];
	logic [`ICACHE_TAG_W-1:0] vt_tag_r  [`ICACHE_VT_N];
	logic [`ICACHE_IDX_W-1:0] vt_idx_r  [`ICACHE_VT_N];
	logic [`ICACHE_VT_N-1:0]  vt_vld_r;
	logic [VT_PTR_W-1:0]      vt_wr_ptr_r;

	logic                     rd_main_hit;
	logic                     pf_main_hit;
	logic [`ICACHE_VT_N-1:0]  rd_vt_match;
	logic [`ICACHE_VT_N-1:0]  pf_vt_match;
	line_t                    rd_vt_line;
	line_t                    pf_vt_line;
	logic                     rd_promote;
	logic                     pf_promote;
	logic                     vt_capture;

	// ***********************************************************************
	// lookups
	// ***********************************************************************

	assign rd_main_hit = vld_r[rd_addr_i.f.idx] && (tag_r[rd_addr_i.f.idx] == rd_addr_i.f.tag);
	assign pf_main_hit = vld_r[pf_addr_i.f.idx] && (tag_r[pf_addr_i.f.idx] == pf_addr_i.f.tag);

	// search every victim entry for both ports
	always_comb begin
		rd_vt_line = '0;
		pf_vt_line = '0;
		for (int i = 0; i < `ICACHE_VT_N; i++) begin
			rd_vt_match[i] = vt_vld_r[i] && (vt_tag_r[i] == rd_addr_i.f.tag) &&
				(vt_idx_r[i] == rd_addr_i.f.idx);
			pf_vt_match[i] = vt_vld_r[i] && (vt_tag_r[i] == pf_addr_i.f.tag) &&
				(vt_idx_r[i] == pf_addr_i.f.idx);
			if (rd_vt_match[i]) begin
				rd_vt_line = vt_data_r[i];
			end
			if (pf_vt_match[i]) begin
				pf_vt_line = vt_data_r[i];
			end
		end
	end

	assign rd_rsp_o.hit  = rd_main_hit | (|rd_vt_match);
	assign rd_rsp_o.data = rd_main_hit ? data_r[rd_addr_i.f.idx] : rd_vt_line;
	assign pf_hit_o      = pf_main_hit | (|pf_vt_match);

	// victim hits move back into the main array
	assign rd_promote = !rd_main_hit && (|rd_vt_match);
	assign pf_promote = pf_prefetching_i && !pf_main_hit && (|pf_vt_match);

	// a fill over a valid line pushes the old one out
	assign vt_capture = fill_vld_i && vld_r[fill_i.idx];

	// ***********************************************************************
	// main array update
	// ***********************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			vld_r <= '0;
		end else begin
			if (fill_vld_i) begin
				vld_r[fill_i.idx] <= 1'b1;
			end
			if (rd_promote) begin
				vld_r[rd_addr_i.f.idx] <= 1'b1;
			end
			if (pf_promote) begin
				vld_r[pf_addr_i.f.idx] <= 1'b1;
			end
		end
	end

	// displaced line on a promotion is simply dropped
	always_ff @(posedge clk) begin
		if (fill_vld_i) begin
			data_r[fill_i.idx] <= fill_i.data;
			tag_r[fill_i.idx]  <= fill_i.tag;
		end
		if (rd_promote) begin
			data_r[rd_addr_i.f.idx] <= rd_vt_line;
			tag_r[rd_addr_i.f.idx]  <= rd_addr_i.f.tag;
		end
		if (pf_promote) begin
			data_r[pf_addr_i.f.idx] <= pf_vt_line;
			tag_r[pf_addr_i.f.idx]  <= pf_addr_i.f.tag;
		end
	end

	// ***********************************************************************
	// victim FIFO, oldest entry overwritten
	// ***********************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			vt_vld_r    <= '0;
			vt_wr_ptr_r <= '0;
		end else if (vt_capture) begin
			vt_vld_r[vt_wr_ptr_r] <= 1'b1;
			vt_wr_ptr_r <= (vt_wr_ptr_r == VT_PTR_W'(`ICACHE_VT_N - 1)) ?
				'0 : vt_wr_ptr_r + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (vt_capture) begin
			vt_data_r[vt_wr_ptr_r] <= data_r[fill_i.idx];
			vt_tag_r[vt_wr_ptr_r]  <= tag_r[fill_i.idx];
			vt_idx_r[vt_wr_ptr_r]  <= fill_i.idx;
		end
	end

	// fill comes from the miss queue, promotion from the fetch side
	a_no_fill_promote_clash: assert property (@(posedge clk) disable iff (rst)
		fill_vld_i |-> !(rd_promote && (rd_addr_i.f.idx == fill_i.idx)) &&
			!(pf_promote && (pf_addr_i.f.idx == fill_i.idx)))
		else $error("icache_mem: fill and promotion hit index %0d together", fill_i.idx);

endmodule

//--- rtl/icache_prefetcher.sv
// next-line prefetch address generation, one-cycle probe and fill request
`timescale 1ns/100ps
`include "icache_params.svh"

module icache_prefetcher (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    enable_i,

	// accepted demand miss
	input  logic                    miss_i,
	input  icache_pkg::fetch_addr_u miss_addr_i,

	// probe into icache_mem
	output icache_pkg::fetch_addr_u pf_addr_o,
	output logic                    pf_prefetching_o,
	input  logic                    pf_hit_i,

	// request to the miss controller
	output logic                    pf_req_o
);

	import icache_pkg::*;

	// byte distance to the following line
	localparam logic [`ICACHE_ADDR_W-1:0] LINE_BYTES = 1 << `ICACHE_OFS_W;

	fetch_addr_u pf_addr_r;
	logic        pf_vld_r;

	// ***********************************************************************
	// next-line address
	// ***********************************************************************

	// probe lives for exactly one cycle after the miss
	always_ff @(posedge clk) begin
		if (rst) begin
			pf_vld_r <= 1'b0;
		end else begin
			pf_vld_r <= miss_i && enable_i;
		end
	end

	// add on the raw view carries from index into tag
	always_ff @(posedge clk) begin
		if (miss_i) begin
			pf_addr_r.raw <= miss_addr_i.raw + LINE_BYTES;
		end
	end

	// ***********************************************************************
	// probe and request
	// ***********************************************************************

	assign pf_addr_o        = pf_addr_r;
	assign pf_prefetching_o = pf_vld_r;

	// fetch the line when neither array holds it
	assign pf_req_o = pf_vld_r && !pf_hit_i;

	// probe result from icache_mem must be resolved while it is presented
	a_pf_hit_known: assert property (@(posedge clk) disable iff (rst)
		pf_prefetching_o |-> !$isunknown(pf_hit_i))
		else $error("icache_prefetcher: probe result unknown while prefetching");

endmodule

//--- rtl/icache_miss_ctrl.sv
// icache_miss_ctrl: in-order pending line queue, memory request issue, fill on response
`timescale 1ns/100ps
`include "icache_params.svh"

module icache_miss_ctrl (
	input  logic                    clk,
	input  logic                    rst,

	// demand side
	input  logic                    fetch_req_i,
	input  icache_pkg::fetch_addr_u fetch_addr_i,
	input  logic                    dmd_hit_i,
	output logic                    miss_o,

	// prefetch side
	input  logic                    pf_req_i,
	input  icache_pkg::fetch_addr_u pf_addr_i,

	// memory
	output logic                    mem_req_vld_o,
	output icache_pkg::mem_req_t    mem_req_o,
	input  logic                    mem_rsp_vld_i,
	input  icache_pkg::mem_rsp_t    mem_rsp_i,

	// fill into icache_mem
	output logic                    fill_vld_o,
	output icache_pkg::cache_fill_t fill_o
);

	import icache_pkg::*;

	localparam int PTR_W = $clog2(`ICACHE_PEND_N);

	mem_req_t                  q_r [`ICACHE_PEND_N];
	logic [`ICACHE_PEND_N-1:0] q_vld_r;
	logic [PTR_W-1:0]          head_r;
	logic [PTR_W-1:0]          tail_r;

	mem_req_t dmd_line;
	mem_req_t pf_line;
	logic     dmd_pend;
	logic     pf_pend;
	logic     q_full;
	logic     pf_enq;
	logic     enq;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(`ICACHE_PEND_N - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// ***********************************************************************
	// request filter
	// ***********************************************************************

	assign dmd_line.tag = fetch_addr_i.f.tag;
	assign dmd_line.idx = fetch_addr_i.f.idx;
	assign pf_line.tag  = pf_addr_i.f.tag;
	assign pf_line.idx  = pf_addr_i.f.idx;

	// lines already on their way
	always_comb begin
		dmd_pend = 1'b0;
		pf_pend  = 1'b0;
		for (int i = 0; i < `ICACHE_PEND_N; i++) begin
			dmd_pend |= q_vld_r[i] && (q_r[i] == dmd_line);
			pf_pend  |= q_vld_r[i] && (q_r[i] == pf_line);
		end
	end

	// a slot freed by this cycle's response can be reused at once
	assign q_full = (&q_vld_r) && !mem_rsp_vld_i;

	// demand wins over prefetch
	assign miss_o = fetch_req_i && !dmd_hit_i && !dmd_pend && !q_full;
	assign pf_enq = pf_req_i && !miss_o && !pf_pend && !q_full;
	assign enq    = miss_o | pf_enq;

	assign mem_req_vld_o = enq;
	assign mem_req_o     = miss_o ? dmd_line : pf_line;

	// ***********************************************************************
	// queue
	// ***********************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			q_vld_r <= '0;
			head_r  <= '0;
			tail_r  <= '0;
		end else begin
			if (mem_rsp_vld_i) begin
				q_vld_r[head_r] <= 1'b0;
				head_r <= ptr_inc(head_r);
			end
			// after the pop, so a refill of the same slot stays valid
			if (enq) begin
				q_vld_r[tail_r] <= 1'b1;
				tail_r <= ptr_inc(tail_r);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (enq) begin
			q_r[tail_r] <= mem_req_o;
		end
	end

	// response pairs with the oldest request
	assign fill_vld_o  = mem_rsp_vld_i;
	assign fill_o.tag  = q_r[head_r].tag;
	assign fill_o.idx  = q_r[head_r].idx;
	assign fill_o.data = mem_rsp_i.data;

	a_rsp_has_request: assert property (@(posedge clk) disable iff (rst)
		mem_rsp_vld_i |-> q_vld_r[head_r])
		else $error("icache_miss_ctrl: memory response with no request pending");

endmodule

//--- rtl/icache_top.sv
// icache_top: instruction cache subsystem, line array, prefetcher and miss controller
`timescale 1ns/100ps

module icache_top (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    pf_enable_i,

	// fetch port
	input  logic                    fetch_req_i,
	input  icache_pkg::fetch_addr_u fetch_addr_i,
	output icache_pkg::fetch_rsp_t  fetch_rsp_o,

	// memory port
	output logic                    mem_req_vld_o,
	output icache_pkg::mem_req_t    mem_req_o,
	input  logic                    mem_rsp_vld_i,
	input  icache_pkg::mem_rsp_t    mem_rsp_i
);

	import icache_pkg::*;

	// prefetch probe path
	fetch_addr_u pf_addr;
	logic        pf_prefetching;
	logic        pf_hit;
	logic        pf_req;

	// accepted demand miss
	logic        miss;

	// fill path
	logic        fill_vld;
	cache_fill_t fill;

	icache_mem icache_mem_i (
		.clk              (clk),
		.rst              (rst),
		.rd_addr_i        (fetch_addr_i),
		.rd_rsp_o         (fetch_rsp_o),
		.pf_addr_i        (pf_addr),
		.pf_prefetching_i (pf_prefetching),
		.pf_hit_o         (pf_hit),
		.fill_vld_i       (fill_vld),
		.fill_i           (fill)
	);

	icache_prefetcher icache_prefetcher_i (
		.clk              (clk),
		.rst              (rst),
		.enable_i         (pf_enable_i),
		.miss_i           (miss),
		.miss_addr_i      (fetch_addr_i),
		.pf_addr_o        (pf_addr),
		.pf_prefetching_o (pf_prefetching),
		.pf_hit_i         (pf_hit),
		.pf_req_o         (pf_req)
	);

	// demand hit comes straight from the lookup
	icache_miss_ctrl icache_miss_ctrl_i (
		.clk           (clk),
		.rst           (rst),
		.fetch_req_i   (fetch_req_i),
		.fetch_addr_i  (fetch_addr_i),
		.dmd_hit_i     (fetch_rsp_o.hit),
		.miss_o        (miss),
		.pf_req_i      (pf_req),
		.pf_addr_i     (pf_addr),
		.mem_req_vld_o (mem_req_vld_o),
		.mem_req_o     (mem_req_o),
		.mem_rsp_vld_i (mem_rsp_vld_i),
		.mem_rsp_i     (mem_rsp_i),
		.fill_vld_o    (fill_vld),
		.fill_o        (fill)
	);

endmodule

//--- testbench/icache_mem_model.sv
// icache_mem_model: behavioral line memory, in-order answers after a fixed delay, pattern data
`timescale 1ns/100ps
`include "icache_params.svh"

module icache_mem_model #(
	parameter int DELAY = 6
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 req_vld_i,
	input  icache_pkg::mem_req_t req_i,
	output logic                 rsp_vld_o,
	output icache_pkg::mem_rsp_t rsp_o
);

	import icache_pkg::*;

	// at most one request per cycle, so a delay line keeps the order
	logic [DELAY-1:0]            vld_pipe;
	mem_req_t                    req_pipe [DELAY];
	logic [`ICACHE_LINE_W/2-1:0] line_word;

	always_ff @(posedge clk) begin
		if (rst) begin
			vld_pipe <= '0;
		end else begin
			vld_pipe <= {vld_pipe[DELAY-2:0], req_vld_i};
		end
	end

	always_ff @(posedge clk) begin
		req_pipe[0] <= req_i;
		for (int i = 1; i < DELAY; i++) begin
			req_pipe[i] <= req_pipe[i-1];
		end
	end

	// line address on top, its inverse below
	assign line_word  = {{`ICACHE_OFS_W{1'b0}}, req_pipe[DELAY-1]};
	assign rsp_vld_o  = vld_pipe[DELAY-1];
	assign rsp_o.data = {line_word, ~line_word};

endmodule

//--- testbench/icache_tb.sv
// icache_tb: fetch table with expected hits and request counts, compare tasks, LFSR, timeout
`timescale 1ns/100ps
`include "icache_params.svh"

module icache_tb;

	import icache_pkg::*;

	typedef struct packed {
		fetch_addr_u addr;
		logic        pf_en;
		logic        exp_hit;
		logic [7:0]  exp_cnt;
	} entry_t;

	logic        clk;
	logic        rst;
	logic        pf_enable;
	logic        fetch_req;
	fetch_addr_u fetch_addr;
	fetch_rsp_t  fetch_rsp;
	logic        mem_req_vld;
	mem_req_t    mem_req;
	logic        mem_rsp_vld;
	mem_rsp_t    mem_rsp;

	entry_t                   tbl [$];
	mem_req_t                 req_log [$];
	logic [`ICACHE_TAG_W-1:0] tags [9];
	logic [15:0]              lfsr;
	mem_req_t                 exp_last;
	logic                     table_built;
	int                       cur_entry;
	int                       prev_cnt;
	int                       rsp_errs = 0;
	int                       req_errs = 0;
	int                       other_errs = 0;

	icache_top icache_top_i (
		.clk           (clk),
		.rst           (rst),
		.pf_enable_i   (pf_enable),
		.fetch_req_i   (fetch_req),
		.fetch_addr_i  (fetch_addr),
		.fetch_rsp_o   (fetch_rsp),
		.mem_req_vld_o (mem_req_vld),
		.mem_req_o     (mem_req),
		.mem_rsp_vld_i (mem_rsp_vld),
		.mem_rsp_i     (mem_rsp)
	);

	icache_mem_model #(.DELAY(6)) icache_mem_model_i (
		.clk       (clk),
		.rst       (rst),
		.req_vld_i (mem_req_vld),
		.req_i     (mem_req),
		.rsp_vld_o (mem_rsp_vld),
		.rsp_o     (mem_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ***********************************************************************
	// expected values
	// ***********************************************************************

	function automatic mem_req_t line_of(input fetch_addr_u a);
		mem_req_t r;
		r.tag = a.f.tag;
		r.idx = a.f.idx;
		return r;
	endfunction

	// memory content: line address above, inverse below
	function automatic line_t pattern(input mem_req_t l);
		logic [`ICACHE_LINE_W/2-1:0] w;
		w = {{`ICACHE_OFS_W{1'b0}}, l};
		return {w, ~w};
	endfunction

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw_tag(output logic [`ICACHE_TAG_W-1:0] tag);
		tag = '0;
		for (int i = 0; i < `ICACHE_TAG_W; i++) begin
			lfsr = lfsr_step(lfsr);
			tag = {tag[`ICACHE_TAG_W-2:0], lfsr[0]};
		end
	endtask

	// conflict tests need distinct tags
	task automatic draw_tags();
		logic [`ICACHE_TAG_W-1:0] t;
		logic                     dup;
		for (int n = 0; n < 9; n++) begin
			do begin
				draw_tag(t);
				dup = 1'b0;
				for (int k = 0; k < n; k++) begin
					dup |= (tags[k] == t);
				end
			end while (dup);
			tags[n] = t;
		end
	endtask

	task automatic add_entry(input logic [`ICACHE_TAG_W-1:0] tag,
		input logic [`ICACHE_IDX_W-1:0] idx, input logic [`ICACHE_OFS_W-1:0] ofs,
		input logic pf, input logic hit, input int cnt);
		entry_t e;
		e.addr.f.tag = tag;
		e.addr.f.idx = idx;
		e.addr.f.ofs = ofs;
		e.pf_en      = pf;
		e.exp_hit    = hit;
		e.exp_cnt    = 8'(cnt);
		tbl.push_back(e);
	endtask

	task automatic build_table();
		draw_tags();
		// cold miss, then the same line at another offset
		add_entry(22'h000123, 7'd5, 3'd0, 1'b0, 1'b0, 1);
		add_entry(22'h000123, 7'd5, 3'd4, 1'b0, 1'b1, 1);
		// next-line prefetch on, then off
		add_entry(22'h000456, 7'd20, 3'd0, 1'b1, 1'b0, 3);
		add_entry(22'h000456, 7'd21, 3'd2, 1'b1, 1'b1, 3);
		add_entry(22'h000456, 7'd40, 3'd0, 1'b0, 1'b0, 4);
		add_entry(22'h000456, 7'd41, 3'd0, 1'b0, 1'b0, 5);
		// three tags at one index, first two pushed to the victim FIFO
		for (int k = 0; k < 3; k++) begin
			add_entry(tags[k], 7'd60, 3'd0, 1'b0, 1'b0, 6 + k);
		end
		for (int k = 0; k < 4; k++) begin
			add_entry(tags[k % 2], 7'd60, 3'd6, 1'b0, 1'b1, 8);
		end
		// six tags, five evictions wrap the FIFO past the first victim
		for (int k = 0; k < 6; k++) begin
			add_entry(tags[3 + k], 7'd90, 3'd0, 1'b0, 1'b0, 9 + k);
		end
		add_entry(tags[3], 7'd90, 3'd0, 1'b0, 1'b0, 15);
		add_entry(tags[5], 7'd90, 3'd0, 1'b0, 1'b1, 15);
		// prefetch probe finds the next line in the victim FIFO
		add_entry(tags[6], 7'd89, 3'd0, 1'b1, 1'b0, 16);
		add_entry(tags[6], 7'd90, 3'd0, 1'b1, 1'b1, 16);
	endtask

	// ***********************************************************************
	// compare tasks
	// ***********************************************************************

	task automatic check_rsp(input fetch_rsp_t exp_rsp, input fetch_rsp_t got);
		if (got.hit !== exp_rsp.hit) begin
			rsp_errs++;
			$display("Error at %0t: fetch_rsp_o.hit expected %0b got %0b",
				$time, exp_rsp.hit, got.hit);
		end else if (exp_rsp.hit && (got.data !== exp_rsp.data)) begin
			rsp_errs++;
			$display("Error at %0t: fetch_rsp_o.data expected %h got %h",
				$time, exp_rsp.data, got.data);
		end
	endtask

	task automatic check_req(input mem_req_t exp_req, input mem_req_t got,
		input int exp_cnt, input int got_cnt);
		if (got_cnt != exp_cnt) begin
			req_errs++;
			$display("Error at %0t: request count expected %0d got %0d",
				$time, exp_cnt, got_cnt);
		end
		if (got !== exp_req) begin
			req_errs++;
			$display("Error at %0t: mem_req_o expected %h got %h", $time, exp_req, got);
		end
	endtask

	// every strobe is taken just before the edge that accepts it
	always @(negedge clk) begin
		#2;
		if (!rst && mem_req_vld) begin
			req_log.push_back(mem_req);
		end
	end

	// ***********************************************************************
	// one table entry, retried every 10 cycles until it hits
	// ***********************************************************************

	task automatic run_entry(input entry_t e, input int prev);
		fetch_rsp_t  exp_rsp;
		fetch_addr_u next_addr;
		mem_req_t    got_last;
		logic        first;
		logic        done;
		int          n_new;
		exp_rsp.data = pattern(line_of(e.addr));
		first = 1'b1;
		done  = 1'b0;
		while (!done) begin
			@(negedge clk);
			pf_enable  = e.pf_en;
			fetch_addr = e.addr;
			fetch_req  = 1'b1;
			#1;
			if (first || fetch_rsp.hit) begin
				exp_rsp.hit = first ? e.exp_hit : 1'b1;
				check_rsp(exp_rsp, fetch_rsp);
			end
			if (first && !fetch_rsp.hit && !mem_req_vld) begin
				other_errs++;
				$display("at %0t: a miss on line %h sent no memory request",
					$time, line_of(e.addr));
			end
			done  = fetch_rsp.hit;
			first = 1'b0;
			@(negedge clk);
			fetch_req = 1'b0;
			if (!done) begin
				repeat (8) @(negedge clk);
			end
		end
		// demand goes out first, a prefetch after it
		n_new = int'(e.exp_cnt) - prev;
		next_addr.raw = e.addr.raw + (`ICACHE_ADDR_W'(1) << `ICACHE_OFS_W);
		if (n_new == 1) begin
			exp_last = line_of(e.addr);
		end else if (n_new == 2) begin
			exp_last = line_of(next_addr);
		end
		got_last = (req_log.size() > 0) ? req_log[$] : '0;
		check_req(exp_last, got_last, int'(e.exp_cnt), req_log.size());
	endtask

	initial begin
		rst         = 1'b1;
		pf_enable   = 1'b0;
		fetch_req   = 1'b0;
		fetch_addr  = '0;
		exp_last    = '0;
		cur_entry   = 0;
		table_built = 1'b0;
		lfsr        = 16'd9765;
		build_table();
		table_built = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		prev_cnt = 0;
		for (int i = 0; i < tbl.size(); i++) begin
			cur_entry = i;
			run_entry(tbl[i], prev_cnt);
			prev_cnt = int'(tbl[i].exp_cnt);
		end
		repeat (2) @(negedge clk);
		$display("errors: fetch response %0d, memory request %0d, other %0d",
			rsp_errs, req_errs, other_errs);
		if (rsp_errs + req_errs + other_errs == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// 40 cycles per table entry
	initial begin
		int cycle_cnt;
		int limit;
		cycle_cnt = 0;
		wait (table_built);
		limit = tbl.size() * 40;
		while (cycle_cnt < limit) begin
			@(posedge clk);
			cycle_cnt++;
		end
		other_errs++;
		$display("timeout after %0d cycles, entry %0d never completed", limit, cur_entry);
		$display("errors: fetch response %0d, memory request %0d, other %0d",
			rsp_errs, req_errs, other_errs);
		$display("TB FAILED");
		$finish;
	end

endmodule

//--- all.f
+incdir+rtl
rtl/icache_pkg.sv
rtl/icache_mem.sv
rtl/icache_prefetcher.sv
rtl/icache_miss_ctrl.sv
rtl/icache_top.sv
testbench/icache_mem_model.sv
testbench/icache_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module icache_tb -f all.f \
	--Mdir obj_dir -o icache_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "compile failed, see build.log"
	exit 1
fi

./obj_dir/icache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "TB PASSED" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
